/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_frontend_tb
FILELIST  = fetch_frontend.f
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* fetch_frontend.f */
logic/fetch_pkg.sv
logic/branch_predictor.sv
logic/fetch_pc_unit.sv
logic/branch_resolver.sv
logic/fetch_frontend.sv
test/fetch_frontend_chk.sv
test/fetch_frontend_tb.sv

/* logic/branch_predictor.sv */
`timescale 1ns/1ns

module branch_predictor #(
    parameter int TABLE_SIZE = 512
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Lookup from the fetch stage
    input  logic [fetch_pkg::XLEN-1:0] lookup_pc_i,
    input  logic                       is_cond_i,
    input  logic                       is_uncond_i,

    // Training from the resolver
    input  logic                       upd_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] upd_pc_i,
    input  logic                       upd_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] upd_target_i,

    // Same-cycle prediction
    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(TABLE_SIZE);

    // Counter table and jump target table, no tags
    pred_state_t      cnt_table [TABLE_SIZE];
    logic [XLEN-1:0]  tgt_table [TABLE_SIZE];

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] upd_idx;
    pred_state_t      lookup_cnt;
    pred_state_t      upd_cnt;
    pred_state_t      upd_cnt_next;

    // Index starts at bit 1 so halfword aligned PCs still spread out
    assign lookup_idx = lookup_pc_i[IDX_W:1];
    assign upd_idx    = upd_pc_i[IDX_W:1];

    assign lookup_cnt = cnt_table[lookup_idx];
    assign upd_cnt    = cnt_table[upd_idx];

    // Saturating step of the counter being trained
    always_comb begin
        upd_cnt_next = upd_cnt;
        if (upd_taken_i) begin
            if (upd_cnt != TAKEN_STRONG) begin
                upd_cnt_next = pred_state_t'(upd_cnt + 2'd1);
            end
        end else begin
            if (upd_cnt != NOT_TAKEN_STRONG) begin
                upd_cnt_next = pred_state_t'(upd_cnt - 2'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                cnt_table[i] <= NOT_TAKEN_STRONG;
            end
        end else if (upd_valid_i) begin
            cnt_table[upd_idx] <= upd_cnt_next;
        end
    end

    // Target written only on taken outcomes
    always_ff @(posedge clk) begin
        if (upd_valid_i && upd_taken_i) begin
            tgt_table[upd_idx] <= upd_target_i;
        end
    end

    // Only predict taken when the fetched word can actually transfer control
    assign pred_taken_o  = lookup_cnt[1] && (is_cond_i || is_uncond_i);
    assign pred_target_o = tgt_table[lookup_idx];

endmodule

/* logic/branch_resolver.sv */
`timescale 1ns/1ns

module branch_resolver (
    // Outcome strobes from execute, at most one meaningful per cycle
    input  logic                       res_branch_i,
    input  logic                       res_jal_i,
    input  logic                       res_jalr_i,

    input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
    input  logic                       res_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_target_i,

    // Prediction that travelled down with the instruction
    input  logic                       res_pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_pred_target_i,

    // Table training
    output logic                       upd_valid_o,
    output logic [fetch_pkg::XLEN-1:0] upd_pc_o,
    output logic                       upd_taken_o,
    output logic [fetch_pkg::XLEN-1:0] upd_target_o,

    // Fetch correction
    output logic                       redirect_o,
    output logic [fetch_pkg::XLEN-1:0] redirect_pc_o
);
    import fetch_pkg::*;

    logic            actual_taken;
    logic [XLEN-1:0] fall_through_pc;
    logic            dir_wrong;
    logic            tgt_wrong;

    assign upd_valid_o = res_branch_i || res_jal_i || res_jalr_i;

    // Branch first, then the jumps
    // Jumps are always taken whatever res_taken_i says
    always_comb begin
        if (res_branch_i) begin
            actual_taken = res_taken_i;
        end else if (res_jal_i || res_jalr_i) begin
            actual_taken = 1'b1;
        end else begin
            actual_taken = 1'b0;
        end
    end

    assign upd_pc_o     = res_pc_i;
    assign upd_taken_o  = actual_taken;
    assign upd_target_o = res_target_i;

    // Mispredict detection
    assign dir_wrong = res_pred_taken_i != actual_taken;
    assign tgt_wrong = actual_taken && (res_pred_target_i != res_target_i);

    assign redirect_o = upd_valid_o && (dir_wrong || tgt_wrong);

    assign fall_through_pc = res_pc_i + XLEN'(4);
    assign redirect_pc_o   = actual_taken ? res_target_i : fall_through_pc;

endmodule

/* logic/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend #(
    parameter int                         TABLE_SIZE = 512,
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC   = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall_i,
    input  logic [fetch_pkg::XLEN-1:0] instr_i,

    // Execute-stage outcomes
    input  logic                       res_branch_i,
    input  logic                       res_jal_i,
    input  logic                       res_jalr_i,
    input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
    input  logic                       res_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_target_i,
    input  logic                       res_pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_pred_target_i,

    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o,
    output logic                       redirect_o,
    output logic [fetch_pkg::XLEN-1:0] redirect_pc_o
);
    import fetch_pkg::*;

    logic            is_cond;
    logic            is_uncond;
    logic            upd_valid;
    logic [XLEN-1:0] upd_pc;
    logic            upd_taken;
    logic [XLEN-1:0] upd_target;

    fetch_pc_unit #(
        .RESET_PC      (RESET_PC)
    ) u_pc_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (stall_i),
        .instr_i       (instr_i),
        .pred_taken_i  (pred_taken_o),
        .pred_target_i (pred_target_o),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o),
        .fetch_pc_o    (fetch_pc_o),
        .is_cond_o     (is_cond),
        .is_uncond_o   (is_uncond)
    );

    // Lookup runs on the same PC the memory is answering
    branch_predictor #(
        .TABLE_SIZE    (TABLE_SIZE)
    ) u_predictor (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_pc_i   (fetch_pc_o),
        .is_cond_i     (is_cond),
        .is_uncond_i   (is_uncond),
        .upd_valid_i   (upd_valid),
        .upd_pc_i      (upd_pc),
        .upd_taken_i   (upd_taken),
        .upd_target_i  (upd_target),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    branch_resolver u_resolver (
        .res_branch_i      (res_branch_i),
        .res_jal_i         (res_jal_i),
        .res_jalr_i        (res_jalr_i),
        .res_pc_i          (res_pc_i),
        .res_taken_i       (res_taken_i),
        .res_target_i      (res_target_i),
        .res_pred_taken_i  (res_pred_taken_i),
        .res_pred_target_i (res_pred_target_i),
        .upd_valid_o       (upd_valid),
        .upd_pc_o          (upd_pc),
        .upd_taken_o       (upd_taken),
        .upd_target_o      (upd_target),
        .redirect_o        (redirect_o),
        .redirect_pc_o     (redirect_pc_o)
    );

endmodule

/* logic/fetch_pc_unit.sv */
`timescale 1ns/1ns

module fetch_pc_unit #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall_i,

    // Word returned by the instruction memory for the current PC
    input  logic [fetch_pkg::XLEN-1:0] instr_i,

    // Prediction for the current PC
    input  logic                       pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,

    // Correction from the execute stage
    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,

    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    output logic                       is_cond_o,
    output logic                       is_uncond_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_seq;
    logic [6:0]      opcode;

    assign pc_seq = pc_q + XLEN'(4);

    // Redirect wins over stall, stall wins over the prediction
    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else if (pred_taken_i) begin
            pc_next = pred_target_i;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc_o = pc_q;

    // Pre-decode
    assign opcode = instr_i[6:0];

    always_comb begin
        is_cond_o   = 1'b0;
        is_uncond_o = 1'b0;
        case (opcode)
            OPC_BRANCH: begin
                is_cond_o = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                is_uncond_o = 1'b1;
            end
            default: begin
                is_cond_o   = 1'b0;
                is_uncond_o = 1'b0;
            end
        endcase
    end

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // Word and address width of the core
    localparam int XLEN = 32;

    // 2-bit saturating counter, upper bit set means predict taken
    typedef enum logic [1:0] {
        NOT_TAKEN_STRONG = 2'b00,
        NOT_TAKEN_WEAK   = 2'b01,
        TAKEN_WEAK       = 2'b10,
        TAKEN_STRONG     = 2'b11
    } pred_state_t;

    // Major opcodes of the control transfer instructions
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

/* test/fetch_frontend_chk.sv */
`timescale 1ns/1ns

module fetch_frontend_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic [fetch_pkg::XLEN-1:0] instr_i,
    input logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    input logic                       pred_taken_o,
    input logic                       redirect_o,
    input logic [fetch_pkg::XLEN-1:0] redirect_pc_o
);
    import fetch_pkg::*;

    // Redirect lands on the corrected address one cycle later
    redirect_lands: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |=> fetch_pc_o == $past(redirect_pc_o))
        else $error("redirect did not move the fetch PC to the redirect address");

    // Only control transfer words may be predicted taken
    pred_needs_ctl: assert property (@(posedge clk) disable iff (!rst_n)
        pred_taken_o |-> (instr_i[6:0] == OPC_BRANCH || instr_i[6:0] == OPC_JAL
                          || instr_i[6:0] == OPC_JALR))
        else $error("prediction taken for a word that is no branch or jump");

    // Tables come out of reset untrained
    no_pred_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !pred_taken_o)
        else $error("prediction taken in the first cycle after reset");

endmodule

bind fetch_frontend fetch_frontend_chk u_chk (.*);

/* test/fetch_frontend_tb.sv */
`timescale 1ns/1ns

module fetch_frontend_tb;

    localparam int          TS       = 512;
    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [6:0]  OP_BR    = 7'b1100011;
    localparam logic [6:0]  OP_JAL   = 7'b1101111;
    localparam logic [6:0]  OP_JALR  = 7'b1100111;
    localparam logic [6:0]  OP_IMM   = 7'b0010011;
    // Reset plus the six tests, in cycles
    localparam int RUN_CYCLES = 10 + 8 + 12 + 4 + 12 + 9 + 2;
    localparam int LIMIT      = 2 * RUN_CYCLES;

    logic clk = 1'b0;
    logic rst_n, stall_i, res_branch_i, res_jal_i, res_jalr_i, res_taken_i, res_pred_taken_i;
    logic [31:0] instr_i, res_pc_i, res_target_i, res_pred_target_i;
    logic [31:0] fetch_pc_o, pred_target_o, redirect_pc_o;
    logic pred_taken_o, redirect_o;

    integer seed = 4509;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    string test_name;

    // Reference model
    int unsigned cnt_m [TS];
    logic [31:0] tgt_m [TS];
    logic [31:0] exp_pc;
    logic [31:0] cur_instr, cur_pc, cur_tgt, cur_ptgt;
    logic [2:0]  cur_kind;
    logic        cur_stall, cur_taken, cur_ptaken;

    fetch_frontend #(.TABLE_SIZE(TS), .RESET_PC(RESET_PC)) UUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run stopped, the cycle limit of %0d was reached", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic int idx_of(input logic [31:0] pc);
        return int'((pc >> 1) & (TS - 1));
    endfunction

    function automatic logic is_ctl(input logic [31:0] w);
        return w[6:0] == OP_BR || w[6:0] == OP_JAL || w[6:0] == OP_JALR;
    endfunction

    function automatic logic exp_pred();
        return cnt_m[idx_of(exp_pc)] >= 2 && is_ctl(cur_instr);
    endfunction

    // Kind bits: 2 branch, 1 JAL, 0 JALR
    function automatic logic actual_taken();
        return cur_kind[2] ? cur_taken : (cur_kind[1] | cur_kind[0]);
    endfunction

    function automatic logic exp_redirect();
        logic act;
        act = actual_taken();
        return cur_kind != 3'b000 && (cur_ptaken != act || (act && cur_ptgt != cur_tgt));
    endfunction

    function automatic logic [31:0] exp_redirect_pc();
        return actual_taken() ? cur_tgt : cur_pc + 32'd4;
    endfunction

    function automatic logic [31:0] rand_target();
        return $random(seed) & 32'hFFFF_FFFC;
    endfunction

    task automatic check(input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // Applies one clock edge to the model with the inputs that were held before it
    task automatic model_edge();
        logic [31:0] ptgt;
        logic p;
        int i;
        p = exp_pred();
        ptgt = tgt_m[idx_of(exp_pc)];
        if (exp_redirect()) exp_pc = exp_redirect_pc();
        else if (cur_stall) exp_pc = exp_pc;
        else if (p) exp_pc = ptgt;
        else exp_pc = exp_pc + 32'd4;
        if (cur_kind != 3'b000) begin
            i = idx_of(cur_pc);
            if (actual_taken()) begin
                if (cnt_m[i] < 3) cnt_m[i]++;
                tgt_m[i] = cur_tgt;
            end else if (cnt_m[i] > 0) begin
                cnt_m[i]--;
            end
        end
    endtask

    task automatic compare_outputs();
        check(exp_pc, fetch_pc_o);
        check(32'(exp_pred()), 32'(pred_taken_o));
        if (exp_pred()) check(tgt_m[idx_of(exp_pc)], pred_target_o);
        check(32'(exp_redirect()), 32'(redirect_o));
        if (exp_redirect()) check(exp_redirect_pc(), redirect_pc_o);
    endtask

    task automatic step(input logic [31:0] instr, input logic stall, input logic [2:0] kind,
                        input logic [31:0] rpc, input logic rtaken, input logic [31:0] rtgt,
                        input logic rptaken, input logic [31:0] rptgt);
        @(posedge clk);
        model_edge();
        instr_i <= instr;
        stall_i <= stall;
        {res_branch_i, res_jal_i, res_jalr_i} <= kind;
        res_pc_i <= rpc;
        res_taken_i <= rtaken;
        res_target_i <= rtgt;
        res_pred_taken_i <= rptaken;
        res_pred_target_i <= rptgt;
        cur_instr = instr;
        cur_stall = stall;
        cur_kind = kind;
        cur_pc = rpc;
        cur_taken = rtaken;
        cur_tgt = rtgt;
        cur_ptaken = rptaken;
        cur_ptgt = rptgt;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle(input logic [31:0] instr, input logic stall);
        step(instr, stall, 3'b000, 32'd0, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    // A wrongly predicted not-taken branch just before pc steers fetch there
    task automatic goto(input logic [31:0] pc);
        step({25'd0, OP_IMM}, 1'b1, 3'b100, pc - 32'd4, 1'b0, 32'd0, 1'b1, 32'd0);
    endtask

    task automatic reset_and_sequential();
        test_name = "reset_and_sequential";
        check(RESET_PC, fetch_pc_o);
        check(32'd0, 32'(pred_taken_o));
        check(32'd0, 32'(redirect_o));
        repeat (4) idle({25'($random(seed) >> 7), OP_IMM}, 1'b0);
        idle({25'd0, OP_IMM}, 1'b1);
        check(RESET_PC + 32'd20, fetch_pc_o);
        repeat (3) idle({25'd0, OP_IMM}, 1'b1);
        check(RESET_PC + 32'd20, fetch_pc_o);
    endtask

    task automatic counter_training(input logic [31:0] p, input logic [31:0] br_w,
                                    input logic [31:0] t);
        test_name = "counter_training";
        goto(p);
        repeat (2) step(br_w, 1'b1, 3'b100, p, 1'b1, t, 1'b1, t);
        idle(br_w, 1'b1);
        check(32'd1, 32'(pred_taken_o));
        check(t, pred_target_o);
        repeat (4) step(br_w, 1'b1, 3'b100, p, 1'b1, t, 1'b1, t);
        step(br_w, 1'b1, 3'b100, p, 1'b0, 32'd0, 1'b0, 32'd0);
        idle(br_w, 1'b1);
        check(32'd1, 32'(pred_taken_o));
        step(br_w, 1'b1, 3'b100, p, 1'b0, 32'd0, 1'b0, 32'd0);
        idle(br_w, 1'b1);
        check(32'd0, 32'(pred_taken_o));
    endtask

    task automatic lookup_gating(input logic [31:0] p, input logic [31:0] t);
        test_name = "lookup_gating";
        step({25'd0, OP_IMM}, 1'b1, 3'b100, p, 1'b1, t, 1'b1, t);
        idle({25'd0, OP_IMM}, 1'b1);
        check(32'd0, 32'(pred_taken_o));
        idle({25'd0, OP_IMM}, 1'b0);
        idle({25'd0, OP_IMM}, 1'b1);
        check(p + 32'd4, fetch_pc_o);
    endtask

    task automatic jump_prediction(input logic [31:0] q, input logic [6:0] opc,
                                   input logic [2:0] kind);
        logic [31:0] t;
        logic [31:0] w;
        test_name = (kind == 3'b010) ? "jal_prediction" : "jalr_prediction";
        t = rand_target();
        w = {25'($random(seed) >> 7), opc};
        goto(q);
        // A fresh counter needs two taken steps to reach weak taken
        repeat (2) step(w, 1'b1, kind, q, 1'b0, t, 1'b1, t);
        idle(w, 1'b1);
        check(32'd1, 32'(pred_taken_o));
        check(t, pred_target_o);
        idle(w, 1'b0);
        idle({25'd0, OP_IMM}, 1'b1);
        check(t, fetch_pc_o);
    endtask

    task automatic mispredict_redirect(input logic [31:0] s, input logic [31:0] s2);
        logic [31:0] t3;
        logic [31:0] t4;
        test_name = "mispredict_redirect";
        t3 = rand_target();
        t4 = rand_target() ^ 32'h0000_0010;
        goto(s);
        step({25'd0, OP_IMM}, 1'b1, 3'b100, s2, 1'b1, t3, 1'b0, 32'd0);
        check(32'd1, 32'(redirect_o));
        check(t3, redirect_pc_o);
        idle({25'd0, OP_IMM}, 1'b1);
        check(t3, fetch_pc_o);
        step({25'd0, OP_IMM}, 1'b1, 3'b100, s2, 1'b1, t4, 1'b1, t3);
        check(32'd1, 32'(redirect_o));
        idle({25'd0, OP_IMM}, 1'b1);
        check(t4, fetch_pc_o);
        step({25'd0, OP_IMM}, 1'b1, 3'b100, s2, 1'b1, t4, 1'b1, t4);
        check(32'd0, 32'(redirect_o));
        idle({25'd0, OP_IMM}, 1'b1);
        check(t4, fetch_pc_o);
        step({25'd0, OP_IMM}, 1'b1, 3'b100, s2, 1'b0, 32'd0, 1'b1, t4);
        check(s2 + 32'd4, redirect_pc_o);
        idle({25'd0, OP_IMM}, 1'b1);
        check(s2 + 32'd4, fetch_pc_o);
    endtask

    task automatic aliasing(input logic [31:0] p, input logic [31:0] br_w,
                            input logic [31:0] t);
        test_name = "aliasing";
        goto(p + 32'(2 * TS));
        idle(br_w, 1'b1);
        check(32'd1, 32'(pred_taken_o));
        check(t, pred_target_o);
    endtask

    initial begin
        logic [31:0] br_w;
        logic [31:0] t;
        rst_n <= 1'b0;
        stall_i <= 1'b0;
        // A branch word during reset so the untrained counters are what keeps prediction low
        instr_i <= {25'd0, OP_BR};
        {res_branch_i, res_jal_i, res_jalr_i} <= 3'b000;
        res_pc_i <= '0;
        res_taken_i <= 1'b0;
        res_target_i <= '0;
        res_pred_taken_i <= 1'b0;
        res_pred_target_i <= '0;
        for (int i = 0; i < TS; i++) cnt_m[i] = 0;
        exp_pc = RESET_PC;
        cur_instr = {25'd0, OP_BR};
        cur_stall = 1'b0;
        cur_kind = 3'b000;
        {cur_pc, cur_tgt, cur_ptgt, cur_taken, cur_ptaken} = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        br_w = {25'($random(seed) >> 7), OP_BR};
        t = rand_target();
        reset_and_sequential();
        counter_training(32'h0000_2040, br_w, t);
        lookup_gating(32'h0000_2040, t);
        jump_prediction(32'h0000_3000, OP_JAL, 3'b010);
        jump_prediction(32'h0000_3104, OP_JALR, 3'b001);
        mispredict_redirect(32'h0000_5000, 32'h0000_6008);
        aliasing(32'h0000_2040, br_w, t);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
